// File: rtl/fp_compare.sv
`timescale 1ns/1ps

module fp_compare import fp_misc_pkg::*; (
  input  fp_op_e                 op,
  input  fp_class_t              a_cls,
  input  fp_class_t              b_cls,
  input  logic [DBL_EXP_W-1:0]   a_exp,
  input  logic [DBL_FRAC_W-1:0]  a_frac,
  input  logic [DBL_EXP_W-1:0]   b_exp,
  input  logic [DBL_FRAC_W-1:0]  b_frac,
  output logic                   cmp_true,
  output logic                   pick_b,
  output logic                   both_nan,
  output logic                   nv
);

  logic [DBL_EXP_W+DBL_FRAC_W-1:0] a_mag;
  logic [DBL_EXP_W+DBL_FRAC_W-1:0] b_mag;
  logic mag_lt;
  logic mag_eq;
  logic same_word;
  logic a_lt_b;
  logic a_gt_b;
  logic both_zero;
  logic num_eq;
  logic num_lt;
  logic a_nan;
  logic b_nan;
  logic any_nan;
  logic any_snan;

  // ~~~~~~~~~~~~~~~~~~~~
  // Ordering
  // ~~~~~~~~~~~~~~~~~~~~
  assign a_mag  = {a_exp, a_frac};
  assign b_mag  = {b_exp, b_frac};
  assign mag_lt = a_mag < b_mag;
  assign mag_eq = a_mag == b_mag;

  assign same_word = (a_cls.sign == b_cls.sign) & mag_eq;
  assign a_lt_b    = (a_cls.sign != b_cls.sign) ? a_cls.sign :
                     (a_cls.sign ? (~mag_lt & ~mag_eq) : mag_lt); // Minus zero below plus zero.
  assign a_gt_b    = ~a_lt_b & ~same_word;

  assign both_zero = a_cls.is_zero & b_cls.is_zero;
  assign num_eq    = same_word | both_zero;
  assign num_lt    = a_lt_b & ~both_zero;

  assign a_nan    = a_cls.is_snan | a_cls.is_qnan;
  assign b_nan    = b_cls.is_snan | b_cls.is_qnan;
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_cls.is_snan | b_cls.is_snan;
  assign both_nan = a_nan & b_nan;

  // ~~~~~~~~~~~~~~~~~~~~
  // Results per operation
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    cmp_true = 1'b0;
    pick_b   = 1'b0;
    nv       = 1'b0;
    case (op)
      EQ: begin
        cmp_true = num_eq & ~any_nan;
        nv       = any_snan; // Quiet compare.
      end
      LT, LE: begin
        cmp_true = (num_lt | (op == LE & num_eq)) & ~any_nan;
        nv       = any_nan; // Signaling compare.
      end
      MIN, MAX: begin
        nv = any_snan;
        if (a_nan | b_nan) pick_b = a_nan & ~b_nan; // Take the operand that is a number.
        else pick_b = (op == MIN) ? a_gt_b : a_lt_b;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/fp_misc_core.sv
`timescale 1ns/1ps

module fp_misc_core import fp_misc_pkg::*; (
  input  fp_req_t req,
  output fp_rsp_t rsp
);

  fp_class_t              a_cls;
  fp_class_t              b_cls;
  logic [DBL_EXP_W-1:0]   a_exp;
  logic [DBL_FRAC_W-1:0]  a_frac;
  logic [DBL_EXP_W-1:0]   b_exp;
  logic [DBL_FRAC_W-1:0]  b_frac;
  logic                   cmp_true;
  logic                   pick_b;
  logic                   both_nan;
  logic                   nv;
  logic [CLASS_W-1:0]     class_mask;
  logic                   a_normal;
  fp_word_u               canon_nan;

  function automatic fp_word_u pack_word(input fp_fmt_e fmt, input logic sign,
                                         input logic [DBL_EXP_W-1:0] e,
                                         input logic [DBL_FRAC_W-1:0] f);
    fp_word_u w;
    if (fmt == FMT_DBL) begin
      w.dbl.sign = sign;
      w.dbl.exp  = e;
      w.dbl.frac = f;
    end else begin
      w.sgl.box  = '1; // Single results are NaN-boxed.
      w.sgl.sign = sign;
      w.sgl.exp  = e[DBL_EXP_W-1 -: SGL_EXP_W];
      w.sgl.frac = f[DBL_FRAC_W-1 -: SGL_FRAC_W];
    end
    return w;
  endfunction

  fp_special_case_detect detect_a (.fmt(req.fmt), .word(req.a), .cls(a_cls),
                                   .exp_w(a_exp), .frac_w(a_frac));
  fp_special_case_detect detect_b (.fmt(req.fmt), .word(req.b), .cls(b_cls),
                                   .exp_w(b_exp), .frac_w(b_frac));

  fp_compare compare0 (
    .op(req.op), .a_cls(a_cls), .b_cls(b_cls),
    .a_exp(a_exp), .a_frac(a_frac), .b_exp(b_exp), .b_frac(b_frac),
    .cmp_true(cmp_true), .pick_b(pick_b), .both_nan(both_nan), .nv(nv)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // FCLASS mask
  // ~~~~~~~~~~~~~~~~~~~~
  assign a_normal = ~(a_cls.is_inf | a_cls.is_snan | a_cls.is_qnan |
                      a_cls.is_zero | a_cls.is_subnormal);

  assign class_mask = {a_cls.is_qnan, a_cls.is_snan,
                       ~a_cls.sign & a_cls.is_inf, ~a_cls.sign & a_normal,
                       ~a_cls.sign & a_cls.is_subnormal, ~a_cls.sign & a_cls.is_zero,
                       a_cls.sign & a_cls.is_zero, a_cls.sign & a_cls.is_subnormal,
                       a_cls.sign & a_normal, a_cls.sign & a_cls.is_inf};

  assign canon_nan = (req.fmt == FMT_DBL) ? CANON_NAN_D : CANON_NAN_S;

  // ~~~~~~~~~~~~~~~~~~~~
  // Response select
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rsp = '0;
    case (req.op)
      CLASS: rsp.data = {{(64-CLASS_W){1'b0}}, class_mask}; // Integer results are not boxed.
      EQ, LT, LE: begin
        rsp.data = {63'b0, cmp_true};
        rsp.nv   = nv;
      end
      MIN, MAX: begin
        rsp.nv = nv;
        if (both_nan) rsp.data = canon_nan;
        else if (pick_b) rsp.data = pack_word(req.fmt, b_cls.sign, b_exp, b_frac);
        else rsp.data = pack_word(req.fmt, a_cls.sign, a_exp, a_frac);
      end
      SGNJ:  rsp.data = pack_word(req.fmt, b_cls.sign, a_exp, a_frac);
      SGNJN: rsp.data = pack_word(req.fmt, ~b_cls.sign, a_exp, a_frac);
      SGNJX: rsp.data = pack_word(req.fmt, a_cls.sign ^ b_cls.sign, a_exp, a_frac);
      default: ;
    endcase
  end

endmodule

// File: rtl/fp_misc_ctrl.sv
`timescale 1ns/1ps

module fp_misc_ctrl import fp_misc_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    req,
  output logic    ack,
  input  fp_req_t req_data,
  output fp_req_t cur_req,
  input  fp_rsp_t core_rsp,
  output fp_rsp_t rsp
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_DONE = 2'd2
  } state_e;

  state_e state;

  // ~~~~~~~~~~~~~~~~~~~~
  // Handshake FSM
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
      rsp   <= '0;
    end else begin
      case (state)
        ST_IDLE: if (req) state <= ST_BUSY;
        ST_BUSY: begin
          rsp   <= core_rsp; // Core output settles from cur_req in this cycle.
          ack   <= 1'b1;
          state <= ST_DONE;
        end
        ST_DONE: if (!req) begin
          ack   <= 1'b0;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) cur_req <= req_data; // Held until the next request.
  end

endmodule

// File: rtl/fp_misc_pkg.sv
package fp_misc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Format widths
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;
  localparam int SGL_EXP_W  = 8;
  localparam int SGL_FRAC_W = 23;
  localparam int SGL_BOX_W  = 64 - 1 - SGL_EXP_W - SGL_FRAC_W; // Upper half of the register.
  localparam int CLASS_W    = 10;

  localparam logic [63:0] CANON_NAN_D = 64'h7FF8_0000_0000_0000;
  localparam logic [63:0] CANON_NAN_S = 64'hFFFF_FFFF_7FC0_0000; // Already NaN-boxed.

  // ~~~~~~~~~~~~~~~~~~~~
  // Operand word
  // ~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                  sign;
    logic [DBL_EXP_W-1:0]  exp;
    logic [DBL_FRAC_W-1:0] frac;
  } fp_dbl_t;

  typedef struct packed {
    logic [SGL_BOX_W-1:0]  box;
    logic                  sign;
    logic [SGL_EXP_W-1:0]  exp;
    logic [SGL_FRAC_W-1:0] frac;
  } fp_sgl_t;

  typedef union packed {
    fp_dbl_t dbl;
    fp_sgl_t sgl;
  } fp_word_u;

  typedef enum logic {
    FMT_SGL = 1'b0,
    FMT_DBL = 1'b1
  } fp_fmt_e;

  typedef enum logic [3:0] {
    CLASS = 4'd0,
    EQ    = 4'd1,
    LT    = 4'd2,
    LE    = 4'd3,
    MIN   = 4'd4,
    MAX   = 4'd5,
    SGNJ  = 4'd6,
    SGNJN = 4'd7,
    SGNJX = 4'd8
  } fp_op_e;

  typedef struct packed {
    logic sign;
    logic is_inf;
    logic is_snan;
    logic is_qnan;
    logic is_zero;
    logic is_subnormal;
  } fp_class_t;

  typedef struct packed {
    fp_op_e   op;
    fp_fmt_e  fmt;
    fp_word_u a;
    fp_word_u b;
  } fp_req_t;

  typedef struct packed {
    fp_word_u data;
    logic     nv;
  } fp_rsp_t;

endpackage

// File: rtl/fp_misc_top.sv
`timescale 1ns/1ps

module fp_misc_top import fp_misc_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    req,
  output logic    ack,
  input  fp_req_t req_data,
  output fp_rsp_t rsp
);

  fp_req_t cur_req;
  fp_rsp_t core_rsp;

  // ~~~~~~~~~~~~~~~~~~~~
  // Controller
  // ~~~~~~~~~~~~~~~~~~~~
  fp_misc_ctrl ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .req_data (req_data),
    .cur_req  (cur_req),
    .core_rsp (core_rsp),
    .rsp      (rsp)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~
  fp_misc_core core0 (
    .req (cur_req), // Captured request, stable while busy.
    .rsp (core_rsp)
  );

endmodule

// File: rtl/fp_special_case_detect.sv
`timescale 1ns/1ps

module fp_special_case_detect import fp_misc_pkg::*; (
  input  fp_fmt_e                fmt,
  input  fp_word_u               word,
  output fp_class_t              cls,
  output logic [DBL_EXP_W-1:0]   exp_w,
  output logic [DBL_FRAC_W-1:0]  frac_w
);

  fp_word_u s_word;
  logic     boxed;
  logic     sign;
  logic     exp_ones;
  logic     exp_zero;
  logic     frac_zero;

  assign boxed  = &word.sgl.box;
  assign s_word = boxed ? word : fp_word_u'(CANON_NAN_S); // Bad box reads as canonical NaN.

  // ~~~~~~~~~~~~~~~~~~~~
  // Field select
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (fmt == FMT_DBL) begin
      sign     = word.dbl.sign;
      exp_w    = word.dbl.exp;
      frac_w   = word.dbl.frac;
      exp_ones = &word.dbl.exp;
      exp_zero = ~|word.dbl.exp;
    end else begin
      sign     = s_word.sgl.sign;
      exp_w    = {s_word.sgl.exp, {(DBL_EXP_W-SGL_EXP_W){1'b0}}}; // Left aligned, order kept.
      frac_w   = {s_word.sgl.frac, {(DBL_FRAC_W-SGL_FRAC_W){1'b0}}};
      exp_ones = &s_word.sgl.exp;
      exp_zero = ~|s_word.sgl.exp;
    end
  end

  assign frac_zero = ~|frac_w;

  // ~~~~~~~~~~~~~~~~~~~~
  // Class bits
  // ~~~~~~~~~~~~~~~~~~~~
  assign cls.sign         = sign;
  assign cls.is_inf       = exp_ones & frac_zero;
  assign cls.is_snan      = exp_ones & ~frac_zero & ~frac_w[DBL_FRAC_W-1];
  assign cls.is_qnan      = exp_ones & frac_w[DBL_FRAC_W-1]; // Top fraction bit marks quiet.
  assign cls.is_zero      = exp_zero & frac_zero;
  assign cls.is_subnormal = exp_zero & ~frac_zero; // Kept as is, never flushed.

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fp_misc_tb -f src.f -o fp_misc_sim

status=0
./obj_dir/fp_misc_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then
  echo "Run failed, see sim.log."
  exit 1
fi
echo "Run passed."

// File: src.f
rtl/fp_misc_pkg.sv
rtl/fp_special_case_detect.sv
rtl/fp_compare.sv
rtl/fp_misc_core.sv
rtl/fp_misc_ctrl.sv
rtl/fp_misc_top.sv
test/fp_misc_assertions.sv
test/fp_misc_tb.sv

// File: test/fp_misc_assertions.sv
`timescale 1ns/1ps

module fp_misc_assertions import fp_misc_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    req,
  input logic    ack,
  input fp_rsp_t rsp
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Handshake rules
  // ~~~~~~~~~~~~~~~~~~~~
  ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else $error("ack is high in the cycle after reset.");

  ack_rise_with_req: assert property (
    @(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
    else $error("ack rose while req was low.");

  ack_hold_until_req_low: assert property (
    @(posedge clk) disable iff (!rst_n) ack && req |=> ack)
    else $error("ack fell before req went low.");

  rsp_stable_during_ack: assert property (
    @(posedge clk) disable iff (!rst_n) ack && $past(ack) |-> $stable(rsp))
    else $error("rsp changed while ack was high."); // Response is frozen once acknowledged.

endmodule

// File: test/fp_misc_golden.txt
# op fmt a b data nv, all hex
# op 0=CLASS 1=EQ 2=LT 3=LE 4=MIN 5=MAX 6=SGNJ 7=SGNJN 8=SGNJX, fmt 0=single 1=double
0 1 FFF0000000000000 0000000000000000 0000000000000001 0
0 1 BFF0000000000000 0000000000000000 0000000000000002 0
0 1 8000000000000001 0000000000000000 0000000000000004 0
0 1 8000000000000000 0000000000000000 0000000000000008 0
0 1 3FF0000000000000 0000000000000000 0000000000000040 0
0 1 7FF0000000000001 0000000000000000 0000000000000100 0
0 0 FFFFFFFF7F800000 0000000000000000 0000000000000080 0
0 0 FFFFFFFF00000000 0000000000000000 0000000000000010 0
0 0 FFFFFFFF00000001 0000000000000000 0000000000000020 0
0 0 FFFFFFFF7FC00000 0000000000000000 0000000000000200 0
0 0 000000003F800000 0000000000000000 0000000000000200 0
1 1 3FF0000000000000 3FF0000000000000 0000000000000001 0
1 1 8000000000000000 0000000000000000 0000000000000001 0
1 1 3FF0000000000000 7FF8000000000000 0000000000000000 0
1 0 FFFFFFFF7F800001 FFFFFFFF3F800000 0000000000000000 1
2 1 8000000000000000 0000000000000000 0000000000000000 0
2 1 3FF0000000000000 4000000000000000 0000000000000001 0
2 1 BFF0000000000000 8000000000000001 0000000000000001 0
2 0 FFFFFFFF7FC00000 FFFFFFFF3F800000 0000000000000000 1
3 1 8000000000000000 0000000000000000 0000000000000001 0
3 0 FFFFFFFF3F800000 FFFFFFFF3F800000 0000000000000001 0
3 1 4000000000000000 3FF0000000000000 0000000000000000 0
3 1 7FF0000000000001 3FF0000000000000 0000000000000000 1
4 1 3FF0000000000000 4000000000000000 3FF0000000000000 0
4 1 8000000000000000 0000000000000000 8000000000000000 0
4 1 0000000000000000 8000000000000000 8000000000000000 0
4 1 7FF8000000000000 3FF0000000000000 3FF0000000000000 0
4 1 3FF0000000000000 7FF0000000000001 3FF0000000000000 1
4 1 7FF8000000000000 FFF8000000000000 7FF8000000000000 0
5 0 FFFFFFFF7F800001 FFFFFFFF7FC00000 FFFFFFFF7FC00000 1
5 0 000000003F800000 FFFFFFFF3F800000 FFFFFFFF3F800000 0
5 1 8000000000000000 0000000000000000 0000000000000000 0
5 0 FFFFFFFF7FC00000 FFFFFFFF40000000 FFFFFFFF40000000 0
6 1 3FF0000000000000 C000000000000000 BFF0000000000000 0
6 0 FFFFFFFFBF800000 FFFFFFFF40000000 FFFFFFFF3F800000 0
6 0 000000003F800000 FFFFFFFFBF800000 FFFFFFFFFFC00000 0
7 1 3FF0000000000000 4000000000000000 BFF0000000000000 0
7 0 000000003F800000 FFFFFFFFBF800000 FFFFFFFF7FC00000 0
8 1 BFF0000000000000 C000000000000000 3FF0000000000000 0
8 0 FFFFFFFFBF800000 000000000000ABCD FFFFFFFFBF800000 0
8 0 000000003F800000 FFFFFFFFBF800000 FFFFFFFFFFC00000 0

// File: test/fp_misc_tb.sv
`timescale 1ns/1ps

module fp_misc_tb import fp_misc_pkg::*; ();

  logic    clk = 1'b0;
  logic    rst_n;
  logic    req;
  logic    ack;
  fp_req_t req_data;
  fp_rsp_t rsp;

  fp_req_t  vec_req[$];
  fp_word_u vec_data[$];
  logic     vec_nv[$];
  int       vec_line[$];

  int data_errs  = 0;
  int nv_errs    = 0;
  int hs_errs    = 0;
  int other_errs = 0;
  bit loaded     = 1'b0;

  fp_misc_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .req_data (req_data),
    .rsp      (rsp)
  );

  bind fp_misc_top fp_misc_assertions hs_chk (
    .clk(clk), .rst_n(rst_n), .req(req), .ack(ack), .rsp(rsp)
  );

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_word(input string name, input fp_word_u expected,
                            input fp_word_u actual);
    if (actual !== expected) begin
      data_errs++;
      $display("[ERROR] %s data: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_nv(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      nv_errs++;
      $display("[ERROR] %s nv: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    int total;
    total = data_errs + nv_errs + hs_errs + other_errs;
    $display("Errors: data %0d, nv %0d, handshake %0d, other %0d", data_errs, nv_errs,
             hs_errs, other_errs);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Golden vectors
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic load_golden(output bit ok);
    int          fd;
    int          n;
    int          line_no;
    string       text;
    logic [3:0]  f_op;
    logic        f_fmt;
    logic [63:0] f_a;
    logic [63:0] f_b;
    logic [63:0] f_data;
    logic        f_nv;
    fp_req_t     r;
    ok = 1'b0;
    line_no = 0;
    fd = $fopen("test/fp_misc_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file test/fp_misc_golden.txt.");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(text, fd);
        if (n > 0) begin
          line_no++;
          n = $sscanf(text, "%h %h %h %h %h %h", f_op, f_fmt, f_a, f_b, f_data, f_nv);
          if (n == 6) begin // Comment lines do not parse.
            r.op  = fp_op_e'(f_op);
            r.fmt = fp_fmt_e'(f_fmt);
            r.a   = f_a;
            r.b   = f_b;
            vec_req.push_back(r);
            vec_data.push_back(f_data);
            vec_nv.push_back(f_nv);
            vec_line.push_back(line_no);
          end
        end
      end
      $fclose(fd);
      ok = (vec_req.size() > 0);
      if (!ok) $display("The golden file holds no vectors.");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // One transaction
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic run_vector(input int idx);
    int      cycles;
    int      gap;
    fp_op_e  op;
    fp_rsp_t held;
    string   name;
    op   = vec_req[idx].op;
    name = $sformatf("%s line %0d", op.name(), vec_line[idx]);
    req_data = vec_req[idx];
    req      = 1'b1;
    cycles   = 0;
    while (!ack && cycles < 8) begin
      @(posedge clk);
      cycles++;
      @(negedge clk); // Outputs are settled here.
    end
    if (!ack) begin
      hs_errs++;
      $display("%s: ack did not rise within 8 cycles of req.", name);
    end else if (cycles != 2) begin
      hs_errs++;
      $display("%s: ack rose %0d cycles after req instead of 2.", name, cycles);
    end
    check_word(name, vec_data[idx], rsp.data);
    check_nv(name, vec_nv[idx], rsp.nv);
    held = rsp;
    @(posedge clk); // Requester keeps req high for one more cycle.
    @(negedge clk);
    if (!ack || rsp !== held) begin
      hs_errs++;
      $display("%s: ack or rsp changed while req was held high.", name);
    end
    @(posedge clk);
    #1 req = 1'b0;
    cycles = 0;
    while (ack && cycles < 8) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    if (ack) begin
      hs_errs++;
      $display("%s: ack did not fall after req went low.", name);
    end else if (cycles != 1) begin
      hs_errs++;
      $display("%s: ack fell %0d cycles after req instead of 1.", name, cycles);
    end
    gap = $urandom % 4;
    repeat (gap) begin
      @(posedge clk);
      @(negedge clk);
      if (ack || rsp !== held) begin
        hs_errs++;
        $display("%s: ack or rsp changed during the idle gap.", name);
      end
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    bit ok;
    rst_n      = 1'b0;
    req        = 1'b0;
    req_data   = '0;
    void'($urandom(32'h5352));
    load_golden(ok);
    if (!ok) begin
      other_errs++;
      finish_run();
    end else begin
      loaded = 1'b1;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      check_word("reset", '0, rsp.data); // Response register clears in reset.
      check_nv("reset", 1'b0, rsp.nv);
      foreach (vec_req[i]) run_vector(i);
      finish_run();
    end
  end

  initial begin
    wait (loaded);
    #((vec_req.size() * 12 + 20) * 8); // Each transaction fits well inside 12 cycles.
    other_errs++;
    $display("Timeout: the run did not finish within %0d cycles.", vec_req.size() * 12 + 20);
    finish_run();
  end

endmodule
